// File: rtl/icache_geom_pkg.sv
package icache_geom_pkg;

   //////////////////////////////////////////////////////////////////////
   // Cache geometry
   //////////////////////////////////////////////////////////////////////

   // Total capacity in bytes, split evenly over the ways
   localparam int unsigned CACHE_BYTES  = 1024;
   localparam int unsigned NB_WAYS      = 2;
   // One 128-bit word per line
   localparam int unsigned LINE_BYTES   = 16;
   localparam int unsigned NB_SETS      = CACHE_BYTES / (NB_WAYS * LINE_BYTES);

   // Address field widths
   localparam int unsigned FETCH_ADDR_W = 32;
   localparam int unsigned LINE_W       = LINE_BYTES * 8;
   localparam int unsigned OFFSET_W     = $clog2(LINE_BYTES);
   localparam int unsigned INDEX_W      = $clog2(NB_SETS);
   // Whatever is left above offset and set index
   localparam int unsigned TAG_W        = FETCH_ADDR_W - INDEX_W - OFFSET_W;

   // Byte address from the fetch port
   typedef logic [FETCH_ADDR_W-1:0] fetch_addr_t;
   // One full cache line
   typedef logic [LINE_W-1:0]       line_t;
   // Set index, address bits [8:4]
   typedef logic [INDEX_W-1:0]      set_idx_t;
   // Tag, address bits [31:9]
   typedef logic [TAG_W-1:0]        tag_t;

endpackage

// File: rtl/icache_ctrl_pkg.sv
package icache_ctrl_pkg;

   import icache_geom_pkg::*;

   // Controller states
   // COMPARE sees the tag read launched at the grant
   typedef enum logic [2:0] {
      IDLE,
      COMPARE,
      REFILL_REQ,
      REFILL_WAIT,
      FLUSH
   } ctrl_state_t;

   // One bit per way, used for enables, hits and the victim
   typedef logic [NB_WAYS-1:0] way_sel_t;

endpackage

// File: rtl/icache_array_if.sv
`timescale 1ns/1ns

interface icache_array_if
   import icache_geom_pkg::*;
   import icache_ctrl_pkg::*;
();

   // Requests from the controller
   way_sel_t tag_rd_en;
   way_sel_t tag_we;
   way_sel_t data_we;
   // Shared read strobe for the line stores
   logic     rd_en;
   set_idx_t idx;
   tag_t     wtag;
   line_t    wline;
   // Clears every valid bit
   logic     flush;

   // Read data, one element per way
   // each way drives only its own element
   tag_t     rtag  [NB_WAYS];
   logic     rvalid[NB_WAYS];
   line_t    rline [NB_WAYS];

   modport ctrl_mp (
      output tag_rd_en, tag_we, data_we, rd_en, idx, wtag, wline, flush,
      input  rtag, rvalid, rline
   );

   modport tag_mp (
      input  tag_rd_en, tag_we, idx, wtag, flush,
      output rtag, rvalid
   );

   modport data_mp (
      input  rd_en, data_we, idx, wline,
      output rline
   );

endinterface

// File: rtl/icache_tag_way.sv
`timescale 1ns/1ns

module icache_tag_way
   import icache_geom_pkg::*;
#(
   parameter int unsigned way_id = 0
)
(
   input logic            clk_i,
   input logic            rst_i,
   icache_array_if.tag_mp arr
);

   // Tag storage, one entry per set
   tag_t               tag_mem [NB_SETS];
   // Valid flags live in flops so a flush clears them at once
   logic [NB_SETS-1:0] valid_q;

   // Registered read port
   tag_t               rtag_q;
   logic               rvalid_q;

   // Tag write and tag read
   always_ff @(posedge clk_i)
   begin
      if (arr.tag_we[way_id])
      begin
         tag_mem[arr.idx] <= arr.wtag;
      end
      if (arr.tag_rd_en[way_id])
      begin
         rtag_q <= tag_mem[arr.idx];
      end
   end

   // Valid bits
   // Flush wins over a refill write, though both never meet
   always_ff @(posedge clk_i)
   begin
      if (rst_i || arr.flush)
      begin
         valid_q <= '0;
      end
      else if (arr.tag_we[way_id])
      begin
         valid_q[arr.idx] <= 1'b1;
      end
   end

   // Valid bit as seen by the compare stage
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         rvalid_q <= 1'b0;
      end
      else if (arr.tag_rd_en[way_id])
      begin
         rvalid_q <= valid_q[arr.idx];
      end
   end

   assign arr.rtag[way_id]   = rtag_q;
   assign arr.rvalid[way_id] = rvalid_q;

endmodule

// File: rtl/icache_data_way.sv
`timescale 1ns/1ns

module icache_data_way
   import icache_geom_pkg::*;
#(
   parameter int unsigned way_id = 0
)
(
   input logic             clk_i,
   icache_array_if.data_mp arr
);

   // Line storage, one line per set
   line_t line_mem [NB_SETS];
   // Read register, holds its value between reads
   line_t rline_q;

   // Write port, only when this way is the victim
   always_ff @(posedge clk_i)
   begin
      if (arr.data_we[way_id])
      begin
         line_mem[arr.idx] <= arr.wline;
      end
   end

   // Read port
   // All ways read together, the controller picks the hit one
   always_ff @(posedge clk_i)
   begin
      if (arr.rd_en)
      begin
         rline_q <= line_mem[arr.idx];
      end
   end

   assign arr.rline[way_id] = rline_q;

endmodule

// File: rtl/icache_resp_fifo.sv
`timescale 1ns/1ns

module icache_resp_fifo
   import icache_geom_pkg::*;
(
   input  logic  clk_i,
   input  logic  rst_i,

   // Refill response side, no back-pressure
   input  logic  in_valid_i,
   input  line_t in_data_i,

   // Controller side
   output logic  out_valid_o,
   output line_t out_data_o,
   input  logic  out_ready_i
);

   // Two entries with one-bit pointers that wrap by themselves
   line_t       mem_q [2];
   logic        wr_ptr_q;
   logic        rd_ptr_q;
   logic [1:0]  count_q;

   logic        push;
   logic        pop;

   assign push        = in_valid_i;
   assign pop         = out_valid_o && out_ready_i;
   assign out_valid_o = (count_q != 2'd0);
   assign out_data_o  = mem_q[rd_ptr_q];

   // Entry storage
   always_ff @(posedge clk_i)
   begin
      if (push)
      begin
         mem_q[wr_ptr_q] <= in_data_i;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Pointers and fill count
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         wr_ptr_q <= 1'b0;
         rd_ptr_q <= 1'b0;
         count_q  <= 2'd0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr_q <= ~wr_ptr_q;
         end
         if (pop)
         begin
            rd_ptr_q <= ~rd_ptr_q;
         end
         // Push and pop together leave the count alone
         case ({push, pop})
            2'b10:   count_q <= count_q + 2'd1;
            2'b01:   count_q <= count_q - 2'd1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

// File: rtl/icache_controller.sv
`timescale 1ns/1ns

module icache_controller
   import icache_geom_pkg::*;
   import icache_ctrl_pkg::*;
(
   input  logic            clk_i,
   input  logic            rst_i,

   // Fetch port
   input  logic            fetch_req_i,
   input  fetch_addr_t     fetch_addr_i,
   output logic            fetch_gnt_o,
   output logic            fetch_rvalid_o,
   output line_t           fetch_rdata_o,

   // Refill request
   output logic            refill_req_o,
   input  logic            refill_gnt_i,
   output fetch_addr_t     refill_addr_o,

   // Refill response from the buffer
   input  logic            resp_valid_i,
   input  line_t           resp_data_i,
   output logic            resp_ready_o,

   // Flush and status
   input  logic            flush_icache_i,
   output logic            cache_is_flushed_o,
   output logic            idle_state_o,

   // Tag and data stores
   icache_array_if.ctrl_mp arr
);

   ctrl_state_t state_q;
   ctrl_state_t state_d;

   // Address of the fetch in flight
   fetch_addr_t addr_q;
   tag_t        req_tag;
   set_idx_t    req_set;

   way_sel_t    hit;
   logic        any_hit;
   line_t       hit_line;

   way_sel_t    victim;
   way_sel_t    victim_q;
   logic        found_free;
   // Round-robin pointer for the case where both ways are valid
   logic        rr_q;

   logic        flushed_q;
   logic        flush_pending;
   logic        refill_done;

   assign req_tag = addr_q[FETCH_ADDR_W-1 -: TAG_W];
   assign req_set = addr_q[OFFSET_W +: INDEX_W];

   // A flush is only taken again once a refill has dirtied the cache
   assign flush_pending = flush_icache_i && !flushed_q;

   // Flush has priority over a fetch in IDLE
   assign fetch_gnt_o = (state_q == IDLE) && fetch_req_i && !flush_pending;

   // Last cycle of a miss, the buffered line is written and returned
   assign refill_done = (state_q == REFILL_WAIT) && resp_valid_i;

   //////////////////////////////////////////////////////////////////////
   // Hit check and victim choice
   //////////////////////////////////////////////////////////////////////

   // Tags were read at the grant, compare against the held address
   always_comb
   begin
      hit_line = '0;
      for (int w = 0; w < NB_WAYS; w++)
      begin
         hit[w] = arr.rvalid[w] && (arr.rtag[w] == req_tag);
         // at most one way hits, so OR-ing is enough
         if (hit[w])
         begin
            hit_line = hit_line | arr.rline[w];
         end
      end
   end

   assign any_hit = |hit;

   // First invalid way, else the round-robin way
   always_comb
   begin
      victim     = way_sel_t'(1) << rr_q;
      found_free = 1'b0;
      for (int w = 0; w < NB_WAYS; w++)
      begin
         if (!arr.rvalid[w] && !found_free)
         begin
            victim     = '0;
            victim[w]  = 1'b1;
            found_free = 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // FSM
   //////////////////////////////////////////////////////////////////////
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         IDLE:
         begin
            if (flush_pending)
            begin
               state_d = FLUSH;
            end
            else if (fetch_req_i)
            begin
               state_d = COMPARE;
            end
         end
         // Hit returns right here, a miss goes out to memory
         COMPARE:     state_d = any_hit ? IDLE : REFILL_REQ;
         // Hold the request until memory grants it
         REFILL_REQ:  state_d = refill_gnt_i ? REFILL_WAIT : REFILL_REQ;
         REFILL_WAIT: state_d = resp_valid_i ? IDLE : REFILL_WAIT;
         FLUSH:       state_d = IDLE;
         default:     state_d = IDLE;
      endcase
   end

   // Control state
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state_q   <= IDLE;
         rr_q      <= 1'b0;
         flushed_q <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         if (refill_done)
         begin
            rr_q <= ~rr_q;
         end
         // Flushed from the cycle after FLUSH until a line is written
         if (state_q == FLUSH)
         begin
            flushed_q <= 1'b1;
         end
         else if (refill_done)
         begin
            flushed_q <= 1'b0;
         end
      end
   end

   // Fetch address and chosen victim
   always_ff @(posedge clk_i)
   begin
      if (fetch_gnt_o)
      begin
         addr_q <= fetch_addr_i;
      end
      if (state_q == COMPARE)
      begin
         victim_q <= victim;
      end
   end

   // Store requests
   // Index comes straight from the port at the grant, held afterwards
   assign arr.idx       = (state_q == IDLE) ? fetch_addr_i[OFFSET_W +: INDEX_W] : req_set;
   assign arr.rd_en     = fetch_gnt_o;
   assign arr.tag_rd_en = {NB_WAYS{fetch_gnt_o}};
   assign arr.tag_we    = refill_done ? victim_q : '0;
   assign arr.data_we   = refill_done ? victim_q : '0;
   assign arr.wtag      = req_tag;
   assign arr.wline     = resp_data_i;
   assign arr.flush     = (state_q == FLUSH);

   // Processor side
   assign fetch_rvalid_o = ((state_q == COMPARE) && any_hit) || refill_done;
   assign fetch_rdata_o  = (state_q == REFILL_WAIT) ? resp_data_i : hit_line;

   // Memory side, line aligned
   assign refill_req_o  = (state_q == REFILL_REQ);
   assign refill_addr_o = {addr_q[FETCH_ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
   assign resp_ready_o  = (state_q == REFILL_WAIT);

   assign cache_is_flushed_o = flushed_q;
   assign idle_state_o       = (state_q == IDLE);

endmodule

// File: rtl/pri_icache.sv
`timescale 1ns/1ns

module pri_icache
   import icache_geom_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_i,

   // Processor fetch port
   input  logic        fetch_req_i,
   input  fetch_addr_t fetch_addr_i,
   output logic        fetch_gnt_o,
   output logic        fetch_rvalid_o,
   output line_t       fetch_rdata_o,

   // Next memory level
   output logic        refill_req_o,
   input  logic        refill_gnt_i,
   output fetch_addr_t refill_addr_o,
   input  logic        refill_r_valid_i,
   input  line_t       refill_r_data_i,

   // Flush and status
   input  logic        flush_icache_i,
   output logic        cache_is_flushed_o,
   output logic        idle_state_o
);

   // Buffered refill response
   logic  resp_valid;
   line_t resp_data;
   logic  resp_ready;

   icache_array_if arr_if ();

   //////////////////////////////////////////////////////////////////////
   // Controller
   //////////////////////////////////////////////////////////////////////
   icache_controller i_controller (
      .clk_i              ( clk_i              ),
      .rst_i              ( rst_i              ),
      .fetch_req_i        ( fetch_req_i        ),
      .fetch_addr_i       ( fetch_addr_i       ),
      .fetch_gnt_o        ( fetch_gnt_o        ),
      .fetch_rvalid_o     ( fetch_rvalid_o     ),
      .fetch_rdata_o      ( fetch_rdata_o      ),
      .refill_req_o       ( refill_req_o       ),
      .refill_gnt_i       ( refill_gnt_i       ),
      .refill_addr_o      ( refill_addr_o      ),
      .resp_valid_i       ( resp_valid         ),
      .resp_data_i        ( resp_data          ),
      .resp_ready_o       ( resp_ready         ),
      .flush_icache_i     ( flush_icache_i     ),
      .cache_is_flushed_o ( cache_is_flushed_o ),
      .idle_state_o       ( idle_state_o       ),
      .arr                ( arr_if.ctrl_mp     )
   );

   // Tag and line store per way
   for (genvar w = 0; w < NB_WAYS; w++)
   begin : g_way
      icache_tag_way #(
         .way_id ( w )
      ) i_tag_way (
         .clk_i ( clk_i         ),
         .rst_i ( rst_i         ),
         .arr   ( arr_if.tag_mp )
      );

      icache_data_way #(
         .way_id ( w )
      ) i_data_way (
         .clk_i ( clk_i          ),
         .arr   ( arr_if.data_mp )
      );
   end

   // Response buffer, memory cannot be stalled
   icache_resp_fifo i_resp_fifo (
      .clk_i       ( clk_i            ),
      .rst_i       ( rst_i            ),
      .in_valid_i  ( refill_r_valid_i ),
      .in_data_i   ( refill_r_data_i  ),
      .out_valid_o ( resp_valid       ),
      .out_data_o  ( resp_data        ),
      .out_ready_i ( resp_ready       )
   );

endmodule

// File: include/icache_tb_mem.svh
`ifndef ICACHE_TB_MEM_SVH
`define ICACHE_TB_MEM_SVH

// Content of the modelled memory for one line
// Word k of the line at byte address A is (A + 4k) XOR 32'h5A5A0000
function automatic logic [127:0] mem_line(input logic [31:0] line_addr);
   logic [127:0] line;
   line = '0;
   for (int k = 0; k < 4; k++)
   begin
      line[32*k +: 32] = (line_addr + 32'(4 * k)) ^ 32'h5A5A0000;
   end
   return line;
endfunction

`endif

// File: sim/pri_icache_checker.sv
`timescale 1ns/1ns

`include "icache_tb_mem.svh"

module pri_icache_checker
   import icache_geom_pkg::*;
(
   input logic        clk_i,
   input logic        rst_i,
   input fetch_addr_t fetch_addr_i,
   input logic        fetch_gnt_i,
   input logic        fetch_rvalid_i,
   input line_t       fetch_rdata_i,
   input logic        refill_req_i,
   input logic        refill_gnt_i,
   input fetch_addr_t refill_addr_i,
   input logic        cache_is_flushed_i,
   input logic        idle_state_i
);

   // Number of failed assertions
   int unsigned fail_cnt = 0;

   // Line of the fetch in flight
   fetch_addr_t gnt_line_q;
   logic        busy_q;
   // Line of the last completed fetch
   fetch_addr_t last_line_q;
   logic        last_ok_q;
   fetch_addr_t req_line;

   assign req_line = {fetch_addr_i[FETCH_ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

   // Only one fetch is in flight at a time
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         busy_q      <= 1'b0;
         last_ok_q   <= 1'b0;
         gnt_line_q  <= '0;
         last_line_q <= '0;
      end
      else if (fetch_gnt_i)
      begin
         busy_q     <= 1'b1;
         gnt_line_q <= req_line;
      end
      else if (fetch_rvalid_i)
      begin
         busy_q      <= 1'b0;
         last_ok_q   <= 1'b1;
         last_line_q <= gnt_line_q;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Port rules
   //////////////////////////////////////////////////////////////////////

   // Outputs in the first cycle out of reset
   a_reset_values: assert property (@(posedge clk_i)
      $fell(rst_i) |-> !fetch_gnt_i && !fetch_rvalid_i && !refill_req_i
                       && !cache_is_flushed_i && idle_state_i)
      else
      begin
         fail_cnt++;
         $error("ERROR %0t: outputs not at their reset values", $time);
      end

   // Returned line follows the memory rule for the granted line
   a_rdata: assert property (@(posedge clk_i) disable iff (rst_i)
      fetch_rvalid_i |-> fetch_rdata_i == mem_line(gnt_line_q))
      else
      begin
         fail_cnt++;
         $error("ERROR %0t: fetch data does not match memory", $time);
      end

   // A grant only when nothing is in flight and one rvalid per grant
   a_one_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
      (fetch_gnt_i || fetch_rvalid_i) |-> (busy_q == fetch_rvalid_i))
      else
      begin
         fail_cnt++;
         $error("ERROR %0t: grant and rvalid out of step", $time);
      end

   // Refill asks for the aligned granted line while the controller is busy
   a_refill_addr: assert property (@(posedge clk_i) disable iff (rst_i)
      refill_req_i |-> !idle_state_i && refill_addr_i[OFFSET_W-1:0] == '0
                       && refill_addr_i == gnt_line_q)
      else
      begin
         fail_cnt++;
         $error("ERROR %0t: bad refill address %h", $time, refill_addr_i);
      end

   // Request held stable under back-pressure
   a_refill_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      refill_req_i && !refill_gnt_i |=> refill_req_i && $stable(refill_addr_i))
      else
      begin
         fail_cnt++;
         $error("ERROR %0t: refill request dropped or changed", $time);
      end

   // Same line again hits one cycle after the grant
   a_repeat_hit: assert property (@(posedge clk_i) disable iff (rst_i)
      fetch_gnt_i && last_ok_q && !cache_is_flushed_i && req_line == last_line_q
      |=> fetch_rvalid_i && !refill_req_i)
      else
      begin
         fail_cnt++;
         $error("ERROR %0t: repeated fetch did not hit", $time);
      end

   // First fetch after a flush must go to memory
   a_flush_miss: assert property (@(posedge clk_i) disable iff (rst_i)
      $past(fetch_gnt_i && cache_is_flushed_i, 2) |-> refill_req_i
                                                 && refill_addr_i == gnt_line_q)
      else
      begin
         fail_cnt++;
         $error("ERROR %0t: fetch after flush did not refill", $time);
      end

   // Flushed status ends with that refill
   a_flush_clear: assert property (@(posedge clk_i) disable iff (rst_i)
      fetch_rvalid_i && cache_is_flushed_i |=> !cache_is_flushed_i)
      else
      begin
         fail_cnt++;
         $error("ERROR %0t: flushed status kept after refill", $time);
      end

endmodule

// File: sim/tb_pri_icache.sv
`timescale 1ns/1ns

`include "icache_tb_mem.svh"

module tb_pri_icache
   import icache_geom_pkg::*;
();

   logic        clk;
   logic        rst;
   logic        fetch_req;
   fetch_addr_t fetch_addr;
   logic        fetch_gnt;
   logic        fetch_rvalid;
   line_t       fetch_rdata;
   logic        refill_req;
   logic        refill_gnt;
   fetch_addr_t refill_addr;
   logic        refill_r_valid;
   line_t       refill_r_data;
   logic        flush_req;
   logic        cache_is_flushed;
   logic        idle_state;

   // Separate LFSR states for the fetch side and the memory side
   logic [31:0] fetch_lfsr;
   logic [31:0] mem_lfsr;
   int unsigned timeouts;

   pri_icache dut_i (
      .clk_i              ( clk              ),
      .rst_i              ( rst              ),
      .fetch_req_i        ( fetch_req        ),
      .fetch_addr_i       ( fetch_addr       ),
      .fetch_gnt_o        ( fetch_gnt        ),
      .fetch_rvalid_o     ( fetch_rvalid     ),
      .fetch_rdata_o      ( fetch_rdata      ),
      .refill_req_o       ( refill_req       ),
      .refill_gnt_i       ( refill_gnt       ),
      .refill_addr_o      ( refill_addr      ),
      .refill_r_valid_i   ( refill_r_valid   ),
      .refill_r_data_i    ( refill_r_data    ),
      .flush_icache_i     ( flush_req        ),
      .cache_is_flushed_o ( cache_is_flushed ),
      .idle_state_o       ( idle_state       )
   );

   bind pri_icache pri_icache_checker u_checker (
      .clk_i              ( clk_i              ),
      .rst_i              ( rst_i              ),
      .fetch_addr_i       ( fetch_addr_i       ),
      .fetch_gnt_i        ( fetch_gnt_o        ),
      .fetch_rvalid_i     ( fetch_rvalid_o     ),
      .fetch_rdata_i      ( fetch_rdata_o      ),
      .refill_req_i       ( refill_req_o       ),
      .refill_gnt_i       ( refill_gnt_i       ),
      .refill_addr_i      ( refill_addr_o      ),
      .cache_is_flushed_i ( cache_is_flushed_o ),
      .idle_state_i       ( idle_state_o       )
   );

   // 20 ns period
   always #10 clk = ~clk;

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit returned
   function automatic logic [31:0] take_bits(inout logic [31:0] state, input int unsigned n);
      logic [31:0] bits;
      logic        fb;
      bits = '0;
      for (int unsigned i = 0; i < n; i++)
      begin
         fb    = state[31] ^ state[21] ^ state[1] ^ state[0];
         state = {state[30:0], fb};
         bits  = {bits[30:0], fb};
      end
      return bits;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Next-level memory model
   //////////////////////////////////////////////////////////////////////
   initial
   begin
      logic [31:0] delay;
      fetch_addr_t line_addr;
      mem_lfsr       = 32'h0073e982;
      refill_gnt     = 1'b0;
      refill_r_valid = 1'b0;
      refill_r_data  = '0;
      forever
      begin
         @(negedge clk);
         if (refill_req)
         begin
            // Grant after 0 to 3 cycles, answer one cycle later
            delay = take_bits(mem_lfsr, 2);
            repeat (delay) @(negedge clk);
            line_addr  = refill_addr;
            refill_gnt = 1'b1;
            @(negedge clk);
            refill_gnt     = 1'b0;
            refill_r_valid = 1'b1;
            refill_r_data  = mem_line(line_addr);
            @(negedge clk);
            refill_r_valid = 1'b0;
         end
      end
   end

   // One fetch, from request to returned line
   task automatic fetch_line(input fetch_addr_t addr, output logic ok);
      int unsigned wait_cnt;
      ok       = 1'b1;
      wait_cnt = 0;
      @(negedge clk);
      fetch_req  = 1'b1;
      fetch_addr = addr;
      // Grant is combinational, look once the drive has settled
      #1;
      while (!fetch_gnt && wait_cnt < 20)
      begin
         @(negedge clk);
         #1;
         wait_cnt++;
      end
      if (!fetch_gnt)
      begin
         $display("Timeout: fetch of %h was never granted", addr);
         fetch_req = 1'b0;
         ok        = 1'b0;
      end
      else
      begin
         // Taken at the rising edge in between
         @(negedge clk);
         fetch_req = 1'b0;
         wait_cnt  = 0;
         while (!fetch_rvalid && wait_cnt < 50)
         begin
            @(negedge clk);
            wait_cnt++;
         end
         if (!fetch_rvalid)
         begin
            $display("Timeout: no line returned for fetch of %h", addr);
            ok = 1'b0;
         end
      end
   endtask

   // Hold the flush request until the cache reports itself flushed
   task automatic flush_cache(output logic ok);
      int unsigned wait_cnt;
      wait_cnt = 0;
      @(negedge clk);
      flush_req = 1'b1;
      while (!cache_is_flushed && wait_cnt < 20)
      begin
         @(negedge clk);
         wait_cnt++;
      end
      flush_req = 1'b0;
      ok        = cache_is_flushed;
      if (!ok)
      begin
         $display("Timeout: flush was never reported done");
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////
   initial
   begin
      fetch_addr_t addr;
      logic [31:0] bits;
      logic        ok;
      fetch_lfsr = 32'h0073e982;
      timeouts   = 0;
      clk        = 1'b0;
      rst        = 1'b1;
      fetch_req  = 1'b0;
      fetch_addr = '0;
      flush_req  = 1'b0;
      addr       = '0;
      ok         = 1'b1;
      repeat (2) @(negedge clk);
      rst = 1'b0;
      for (int n = 0; n < 400 && ok; n++)
      begin
         // Roughly one flush in eight fetches
         if (take_bits(fetch_lfsr, 3) == 32'd0 && !cache_is_flushed)
         begin
            flush_cache(ok);
         end
         // Half the fetches repeat the previous address
         if (n == 0 || take_bits(fetch_lfsr, 1) == 32'd0)
         begin
            // 8 sets times 8 tags, so ways get evicted
            bits = take_bits(fetch_lfsr, 10);
            addr = {20'h00010, bits[9:7], 2'b00, bits[6:4], bits[3:0]};
         end
         if (ok)
         begin
            fetch_line(addr, ok);
         end
      end
      if (!ok)
      begin
         timeouts++;
      end
      @(negedge clk);
      $display("Assertion failures: %0d, timeouts: %0d",
               dut_i.u_checker.fail_cnt, timeouts);
      if (dut_i.u_checker.fail_cnt == 0 && timeouts == 0)
      begin
         $display("All tests passed!");
      end
      else
      begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// File: all.f
+incdir+include
rtl/icache_geom_pkg.sv
rtl/icache_ctrl_pkg.sv
rtl/icache_array_if.sv
rtl/icache_tag_way.sv
rtl/icache_data_way.sv
rtl/icache_resp_fifo.sv
rtl/icache_controller.sv
rtl/pri_icache.sv
sim/pri_icache_checker.sv
sim/tb_pri_icache.sv

// File: Makefile
TOP := tb_pri_icache
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+1000 2>&1 | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then \
		echo "Simulation FAILED"; \
		exit 1; \
	fi
	@grep -q "All tests passed!" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir $(LOG)
